// ==== vlog.f ====
+incdir+.
lsu_pkg.sv
lsu_unit.sv
fetch_unit.sv
mem_arbiter.sv
data_sram.sv
mem_subsys_top.sv
mem_subsys_checker.sv
tb_mem_subsys.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mem_subsys
FILELIST  = vlog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_mem_subsys.sv ====
// testbench for the memory subsystem top level
// preloads memory through stores, then runs store/load sweeps, misaligned and NOP
// accesses and fetches that overlap LSU traffic, checked against a byte model
// writeback back-pressure comes in random stretches from an LFSR
`timescale 1ns/1ns
`default_nettype none

`include "lsu_consts.svh"

module tb_mem_subsys import lsu_pkg::*; ();

	localparam int wait_limit = 50;

	logic      clock;
	logic      rstn;
	logic      ex_valid_i;
	lsu_req_t  ex_req_i;
	logic      ex_ready_o;
	logic      wb_valid_o;
	lsu_resp_t wb_resp_o;
	logic      wb_ready_i;
	logic      fetch_start_i;
	addr_t     fetch_pc_i;
	logic      fetch_done_o;
	word_t     fetch_insn_o;

	logic [15:0] lfsr = 16'd41347;
	logic [7:0]  ref_mem [`MEM_WORDS*4]; // byte image of the data memory
	mem_op_e     st_ops [3]  = '{ST_B, ST_H, ST_W};
	mem_op_e     ld_ops [5]  = '{LD_B, LD_BU, LD_H, LD_HU, LD_W};
	mem_op_e     mis_ops [4] = '{ST_H, ST_W, LD_H, LD_W};

	mem_subsys_top dut (
		.clock         (clock),
		.rstn          (rstn),
		.ex_valid_i    (ex_valid_i),
		.ex_req_i      (ex_req_i),
		.ex_ready_o    (ex_ready_o),
		.wb_valid_o    (wb_valid_o),
		.wb_resp_o     (wb_resp_o),
		.wb_ready_i    (wb_ready_i),
		.fetch_start_i (fetch_start_i),
		.fetch_pc_i    (fetch_pc_i),
		.fetch_done_o  (fetch_done_o),
		.fetch_insn_o  (fetch_insn_o)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int k = 0; k < n; k++) begin
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic int width_of(input mem_op_e op);
		case (op)
			LD_B, LD_BU, ST_B: return 1;
			LD_H, LD_HU, ST_H: return 2;
			default:           return 4;
		endcase
	endfunction

	function automatic addr_t align(input addr_t a, input mem_op_e op);
		return a & ~(addr_t'(width_of(op)) - addr_t'(1));
	endfunction

	function automatic void store_model(input mem_op_e op, input addr_t a, input word_t d);
		logic [`MEM_AW+1:0] i;
		i = a[`MEM_AW+1:0];
		for (int k = 0; k < width_of(op); k++) begin
			ref_mem[i] = d[8*k +: 8];
			i = i + 1'b1;
		end
	endfunction

	// writeback value predicted from the byte model
	function automatic word_t exp_load(input mem_op_e op, input addr_t a);
		logic [`MEM_AW+1:0] i;
		word_t              w;
		i = a[`MEM_AW+1:0];
		for (int k = 0; k < 4; k++) begin
			w[8*k +: 8] = ref_mem[i];
			i = i + 1'b1;
		end
		case (op)
			LD_B:    return {{24{w[7]}}, w[7:0]};
			LD_BU:   return {24'b0, w[7:0]};
			LD_H:    return {{16{w[15]}}, w[15:0]};
			LD_HU:   return {16'b0, w[15:0]};
			LD_W:    return w;
			default: return a; // stores and NOP give back the address
		endcase
	endfunction

	task automatic fail_run();
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic expect_val(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic require_seen(input logic seen, input string what);
		if (!seen) begin
			$display("timed out waiting for %s", what);
			fail_run();
		end
	endtask

	task automatic compare_resp(input mem_op_e op, input addr_t a, input lsu_resp_t resp,
			input int lat, input int exp_lat);
		expect_val("wb_resp_o.rdata", resp.rdata, exp_load(op, a));
		expect_val("wb_resp_o.misalign", 32'(resp.misalign), 32'h0);
		if (exp_lat > 0)
			expect_val("wb_valid_o latency", 32'(lat), 32'(exp_lat));
	endtask

	// one LSU transaction, lat counts cycles from acceptance to wb_valid_o
	task automatic run_access(input mem_op_e op, input addr_t a, input word_t d,
			output lsu_resp_t resp, output int lat);
		lsu_req_t r;
		int       t;
		int       gap;
		r.op    = op;
		r.addr  = a;
		r.wdata = d;
		@(posedge clock);
		ex_valid_i <= 1'b1;
		ex_req_i   <= r;
		t = 0;
		do begin
			@(negedge clock);
			t++;
		end while (!ex_ready_o && t < wait_limit);
		require_seen(ex_ready_o, "ex_ready_o");
		@(posedge clock); // accepted on this edge
		ex_valid_i <= 1'b0;
		lat = 0;
		do begin
			@(negedge clock);
			lat++;
		end while (!wb_valid_o && lat < wait_limit);
		require_seen(wb_valid_o, "wb_valid_o");
		resp = wb_resp_o;
		gap  = rand_bits(2);
		repeat (gap) begin // writeback stalls, response must hold
			@(negedge clock);
			expect_val("wb_valid_o", 32'(wb_valid_o), 32'h1);
			expect_val("ex_ready_o", 32'(ex_ready_o), 32'h0);
			expect_val("wb_resp_o.rdata", wb_resp_o.rdata, resp.rdata);
		end
		@(posedge clock);
		wb_ready_i <= 1'b1;
		@(posedge clock);
		wb_ready_i <= 1'b0;
	endtask

	task automatic fetch_word(input addr_t pc);
		int t;
		@(posedge clock);
		fetch_start_i <= 1'b1;
		fetch_pc_i    <= pc;
		@(posedge clock);
		fetch_start_i <= 1'b0;
		t = 0;
		do begin
			@(negedge clock);
			t++;
		end while (!fetch_done_o && t < wait_limit);
		require_seen(fetch_done_o, "fetch_done_o");
		expect_val("fetch_insn_o", fetch_insn_o, exp_load(LD_W, align(pc, LD_W)));
	endtask

	initial begin
		lsu_resp_t resp;
		int        lat;
		addr_t     a;
		word_t     d;
		mem_op_e   op;
		addr_t     pcs [12];
		addr_t     las [12];
		word_t     lds [12];
		rstn          <= 1'b0;
		ex_valid_i    <= 1'b0;
		ex_req_i      <= '0;
		wb_ready_i    <= 1'b0;
		fetch_start_i <= 1'b0;
		fetch_pc_i    <= '0;
		repeat (3) @(posedge clock);
		rstn <= 1'b1;
		@(negedge clock);
		expect_val("wb_valid_o", 32'(wb_valid_o), 32'h0);
		expect_val("fetch_done_o", 32'(fetch_done_o), 32'h0);
		expect_val("ex_ready_o", 32'(ex_ready_o), 32'h1);

		for (int w = 0; w < 32; w++) begin // preload the 128 byte window
			a = addr_t'(w * 4);
			d = rand_bits(32);
			run_access(ST_W, a, d, resp, lat);
			store_model(ST_W, a, d);
		end

		repeat (24) begin
			op = st_ops[rand_bits(2) % 3];
			a  = align(rand_bits(7), op);
			d  = rand_bits(32);
			run_access(op, a, d, resp, lat);
			store_model(op, a, d);
			compare_resp(op, a, resp, lat, 3);
			foreach (ld_ops[k]) begin
				run_access(ld_ops[k], align(a, ld_ops[k]), '0, resp, lat);
				compare_resp(ld_ops[k], align(a, ld_ops[k]), resp, lat, 3);
			end
		end

		repeat (8) begin // halfwords on odd bytes, words off a word boundary
			op = mis_ops[rand_bits(2)];
			a  = rand_bits(7);
			if (width_of(op) == 2)
				a[0] = 1'b1;
			else if (a[1:0] == 2'b00)
				a[1] = 1'b1;
			run_access(op, a, rand_bits(32), resp, lat);
			expect_val("wb_resp_o.rdata", resp.rdata, 32'h0);
			expect_val("wb_resp_o.misalign", 32'(resp.misalign), 32'h1);
			expect_val("wb_valid_o latency", 32'(lat), 32'h1);
			run_access(LD_W, align(a, LD_W), '0, resp, lat);
			compare_resp(LD_W, align(a, LD_W), resp, lat, 3);
		end

		repeat (4) begin
			a = rand_bits(32);
			run_access(NOP, a, '0, resp, lat);
			compare_resp(NOP, a, resp, lat, 1);
		end

		// fetch reads the low half while the LSU works in the high half
		for (int k = 0; k < 12; k++) begin
			pcs[k] = rand_bits(6);
			las[k] = 32'h40 | (rand_bits(6) & 32'h3c);
			lds[k] = rand_bits(32);
		end
		fork
			for (int k = 0; k < 12; k++)
				fetch_word(pcs[k]);
			for (int k = 0; k < 12; k++) begin
				lsu_resp_t r2;
				int        l2;
				run_access(ST_W, las[k], lds[k], r2, l2);
				store_model(ST_W, las[k], lds[k]);
				run_access(LD_W, las[k], '0, r2, l2);
				compare_resp(LD_W, las[k], r2, l2, 0);
			end
		join

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mem_subsys_checker.sv ====
// concurrent checks on arbitration and the writeback and fetch handshakes
// bound into the memory subsystem top level, reports through $error
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_checker import lsu_pkg::*; (
	input wire       clock,
	input wire       rstn,
	input wire       f_gnt_i,
	input wire       l_gnt_i,
	input wire       ex_ready_i,
	input wire       wb_valid_i,
	input wire       wb_ready_i,
	input lsu_resp_t wb_resp_i,
	input wire       fetch_done_i
);

	a_one_grant: assert property (@(posedge clock) disable iff (!rstn)
		!(f_gnt_i && l_gnt_i))
		else $error("fetch and load/store granted in the same cycle");

	// writeback response held while stalled
	a_resp_held: assert property (@(posedge clock) disable iff (!rstn)
		wb_valid_i && !wb_ready_i |=> wb_valid_i && $stable(wb_resp_i))
		else $error("writeback response changed under back-pressure");

	a_done_pulse: assert property (@(posedge clock) disable iff (!rstn)
		fetch_done_i |=> !fetch_done_i)
		else $error("fetch done strobe longer than one cycle");

	a_ready_valid: assert property (@(posedge clock) disable iff (!rstn)
		!(ex_ready_i && wb_valid_i))
		else $error("execute ready while writeback valid");

endmodule

bind mem_subsys_top mem_subsys_checker u_chk (
	.clock        (clock),
	.rstn         (rstn),
	.f_gnt_i      (f_gnt),
	.l_gnt_i      (l_gnt),
	.ex_ready_i   (ex_ready_o),
	.wb_valid_i   (wb_valid_o),
	.wb_ready_i   (wb_ready_i),
	.wb_resp_i    (wb_resp_o),
	.fetch_done_i (fetch_done_o)
);

`default_nettype wire

// ==== mem_subsys_top.sv ====
// memory side of the core
// load/store unit and fetch unit share one data memory through the
// round-robin arbiter; read data is broadcast and each peer picks it up
// the cycle after its own grant
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_top import lsu_pkg::*; (
	input  wire       clock,
	input  wire       rstn,
	input  wire       ex_valid_i,
	input  lsu_req_t  ex_req_i,
	output logic      ex_ready_o,
	output logic      wb_valid_o,
	output lsu_resp_t wb_resp_o,
	input  wire       wb_ready_i,
	input  wire       fetch_start_i,
	input  addr_t     fetch_pc_i,
	output logic      fetch_done_o,
	output word_t     fetch_insn_o
);

	logic     f_valid, f_gnt;
	logic     l_valid, l_gnt;
	bus_req_t f_req, l_req;
	logic     mem_en;
	bus_req_t mem_req;
	word_t    mem_rdata;

	lsu_unit u_lsu (
		.clock       (clock),
		.rstn        (rstn),
		.ex_valid_i  (ex_valid_i),
		.ex_req_i    (ex_req_i),
		.ex_ready_o  (ex_ready_o),
		.wb_valid_o  (wb_valid_o),
		.wb_resp_o   (wb_resp_o),
		.wb_ready_i  (wb_ready_i),
		.bus_valid_o (l_valid),
		.bus_req_o   (l_req),
		.bus_gnt_i   (l_gnt),
		.bus_rdata_i (mem_rdata)
	);

	fetch_unit u_fetch (
		.clock         (clock),
		.rstn          (rstn),
		.fetch_start_i (fetch_start_i),
		.fetch_pc_i    (fetch_pc_i),
		.fetch_done_o  (fetch_done_o),
		.fetch_insn_o  (fetch_insn_o),
		.bus_valid_o   (f_valid),
		.bus_req_o     (f_req),
		.bus_gnt_i     (f_gnt),
		.bus_rdata_i   (mem_rdata)
	);

	mem_arbiter u_arb (
		.clock     (clock),
		.rstn      (rstn),
		.f_valid_i (f_valid),
		.f_req_i   (f_req),
		.f_gnt_o   (f_gnt),
		.l_valid_i (l_valid),
		.l_req_i   (l_req),
		.l_gnt_o   (l_gnt),
		.mem_en_o  (mem_en),
		.mem_req_o (mem_req)
	);

	data_sram u_sram (
		.clock       (clock),
		.mem_en_i    (mem_en),
		.mem_req_i   (mem_req),
		.mem_rdata_o (mem_rdata)
	);

endmodule

`default_nettype wire

// ==== data_sram.sv ====
// shared word memory behind the arbiter
// enabled writes touch only strobed bytes, enabled reads register the word
// so it shows up on mem_rdata_o one cycle later
// word address wraps at the memory depth
`timescale 1ns/1ns
`default_nettype none

`include "lsu_consts.svh"

module data_sram import lsu_pkg::*; (
	input  wire      clock,
	input  wire      mem_en_i,
	input  bus_req_t mem_req_i,
	output word_t    mem_rdata_o
);

	word_t              mem [`MEM_WORDS];
	logic [`MEM_AW-1:0] idx;

	assign idx = mem_req_i.addr[`MEM_AW-1:0];

	always_ff @(posedge clock) begin
		if (mem_en_i) begin
			if (mem_req_i.we) begin
				for (int b = 0; b < `STRB_W; b++) begin
					if (mem_req_i.strb[b])
						mem[idx][b*8 +: 8] <= mem_req_i.wdata[b*8 +: 8];
				end
			end else begin
				mem_rdata_o <= mem[idx]; // read port keeps last word
			end
		end
	end

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
// round-robin arbiter for the shared data memory
// fetch and load/store hold their requests until granted; at most one grant
// per cycle, and the grant doubles as the one-cycle memory enable
// on a tie the peer not granted last wins, so load/store wins the first tie
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter import lsu_pkg::*; (
	input  wire      clock,
	input  wire      rstn,
	input  wire      f_valid_i,
	input  bus_req_t f_req_i,
	output logic     f_gnt_o,
	input  wire      l_valid_i,
	input  bus_req_t l_req_i,
	output logic     l_gnt_o,
	output logic     mem_en_o,
	output bus_req_t mem_req_o
);

	logic last_lsu_q; // 0 fetch, 1 load/store

	always_comb begin
		f_gnt_o = 1'b0;
		l_gnt_o = 1'b0;
		if (f_valid_i && l_valid_i) begin
			if (last_lsu_q)
				f_gnt_o = 1'b1;
			else
				l_gnt_o = 1'b1;
		end else begin
			f_gnt_o = f_valid_i;
			l_gnt_o = l_valid_i;
		end
	end

	always_ff @(posedge clock) begin
		if (!rstn)
			last_lsu_q <= 1'b0;
		else if (f_gnt_o || l_gnt_o)
			last_lsu_q <= l_gnt_o;
	end

	assign mem_en_o  = f_gnt_o | l_gnt_o;
	assign mem_req_o = l_gnt_o ? l_req_i : f_req_i;

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
// instruction fetch peer
// a start strobe latches the pc and requests one word read, the word comes
// back with a one-cycle done strobe the cycle after the grant
// starts that arrive while a fetch is pending are dropped
`timescale 1ns/1ns
`default_nettype none

module fetch_unit import lsu_pkg::*; (
	input  wire      clock,
	input  wire      rstn,
	input  wire      fetch_start_i,
	input  addr_t    fetch_pc_i,
	output logic     fetch_done_o,
	output word_t    fetch_insn_o,
	output logic     bus_valid_o,
	output bus_req_t bus_req_o,
	input  wire      bus_gnt_i,
	input  word_t    bus_rdata_i
);

	logic  busy_q;
	logic  done_q;
	addr_t pc_q;

	always_ff @(posedge clock) begin
		if (!rstn) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= busy_q & bus_gnt_i; // data lands one cycle after grant
			if (!busy_q && fetch_start_i)
				busy_q <= 1'b1;
			else if (bus_gnt_i)
				busy_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (!busy_q && fetch_start_i)
			pc_q <= fetch_pc_i;
	end

	// word aligned instructions, low pc bits dropped
	assign bus_valid_o     = busy_q;
	assign bus_req_o.addr  = pc_q >> 2;
	assign bus_req_o.we    = 1'b0;
	assign bus_req_o.strb  = '0;
	assign bus_req_o.wdata = '0;

	assign fetch_done_o = done_q;
	assign fetch_insn_o = done_q ? bus_rdata_i : '0;

endmodule

`default_nettype wire

// ==== lsu_unit.sv ====
// load/store unit between execute and writeback
// takes one request per valid/ready handshake, places store data and strobes
// in the right byte lanes, and shifts and extends load data for writeback
// NOP and misaligned accesses finish without touching the bus
`timescale 1ns/1ns
`default_nettype none

`include "lsu_consts.svh"

module lsu_unit import lsu_pkg::*; (
	input  wire       clock,
	input  wire       rstn,
	input  wire       ex_valid_i,
	input  lsu_req_t  ex_req_i,
	output logic      ex_ready_o,
	output logic      wb_valid_o,
	output lsu_resp_t wb_resp_o,
	input  wire       wb_ready_i,
	output logic      bus_valid_o,
	output bus_req_t  bus_req_o,
	input  wire       bus_gnt_i,
	input  word_t     bus_rdata_i
);

	lsu_state_e state_q, state_d;
	lsu_req_t   req_q;
	lsu_resp_t  resp_q;
	logic       accept;
	logic       ex_misalign;
	logic       skip_bus;
	logic [1:0] off_q;
	strb_t      size_strb;
	word_t      shifted;
	word_t      ld_val;

	function automatic logic [1:0] size_of(input mem_op_e op);
		case (op)
			LD_B, LD_BU, ST_B: size_of = `SZ_B;
			LD_H, LD_HU, ST_H: size_of = `SZ_H;
			default:           size_of = `SZ_W;
		endcase
	endfunction

	function automatic logic is_store(input mem_op_e op);
		is_store = (op == ST_B) || (op == ST_H) || (op == ST_W);
	endfunction

	// halfword on odd byte, word off a word boundary
	function automatic logic misaligned(input mem_op_e op, input logic [1:0] off);
		if (op == NOP)
			misaligned = 1'b0;
		else if (size_of(op) == `SZ_H)
			misaligned = off[0];
		else if (size_of(op) == `SZ_W)
			misaligned = |off;
		else
			misaligned = 1'b0;
	endfunction

	assign ex_ready_o  = (state_q == IDLE);
	assign accept      = ex_valid_i & ex_ready_o;
	assign ex_misalign = misaligned(ex_req_i.op, ex_req_i.addr[1:0]);
	assign skip_bus    = (ex_req_i.op == NOP) | ex_misalign;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE:  if (accept) state_d = skip_bus ? HOLD : ISSUE;
			ISSUE: if (bus_gnt_i) state_d = DATA; // stay until arbiter picks us
			DATA:  state_d = HOLD;
			HOLD:  if (wb_ready_i) state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstn)
			state_q <= IDLE;
		else
			state_q <= state_d;
	end

	// store side: lane placement from the low address bits
	assign off_q = req_q.addr[1:0];

	always_comb begin
		case (size_of(req_q.op))
			`SZ_B:   size_strb = strb_t'(4'b0001);
			`SZ_H:   size_strb = strb_t'(4'b0011);
			default: size_strb = strb_t'(4'b1111);
		endcase
	end

	assign bus_valid_o     = (state_q == ISSUE);
	assign bus_req_o.addr  = req_q.addr >> 2;
	assign bus_req_o.we    = is_store(req_q.op);
	assign bus_req_o.strb  = is_store(req_q.op) ? strb_t'(size_strb << off_q) : '0;
	assign bus_req_o.wdata = req_q.wdata << {off_q, 3'b000};

	// load side: bring the addressed byte down to lane 0, then extend
	assign shifted = bus_rdata_i >> {off_q, 3'b000};

	always_comb begin
		case (req_q.op)
			LD_B:    ld_val = {{24{shifted[7]}}, shifted[7:0]};
			LD_BU:   ld_val = {24'b0, shifted[7:0]};
			LD_H:    ld_val = {{16{shifted[15]}}, shifted[15:0]};
			LD_HU:   ld_val = {16'b0, shifted[15:0]};
			default: ld_val = shifted;
		endcase
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			req_q <= ex_req_i;
			if (skip_bus) begin
				resp_q.rdata    <= ex_misalign ? '0 : ex_req_i.addr;
				resp_q.misalign <= ex_misalign;
			end
		end
		if (state_q == DATA) begin // read data valid this cycle
			resp_q.rdata    <= is_store(req_q.op) ? req_q.addr : ld_val;
			resp_q.misalign <= 1'b0;
		end
	end

	assign wb_valid_o = (state_q == HOLD);
	assign wb_resp_o  = resp_q; // held until writeback takes it

endmodule

`default_nettype wire

// ==== lsu_pkg.sv ====
// shared types for the load/store unit, fetch unit, arbiter and memory
// modules pull this in with a wildcard import in their header
`default_nettype none

`include "lsu_consts.svh"

package lsu_pkg;

	typedef logic [`DATA_W-1:0] word_t;
	typedef logic [`ADDR_W-1:0] addr_t;
	typedef logic [`STRB_W-1:0] strb_t;

	// execute-stage memory operation
	typedef enum logic [3:0] {
		NOP   = 4'h0, // result is the address itself
		LD_B  = 4'h1,
		LD_H  = 4'h2,
		LD_W  = 4'h3,
		LD_BU = 4'h4,
		LD_HU = 4'h5,
		ST_B  = 4'h6,
		ST_H  = 4'h7,
		ST_W  = 4'h8
	} mem_op_e;

	typedef struct packed {
		mem_op_e op;
		addr_t   addr;  // alu result
		word_t   wdata;
	} lsu_req_t;

	typedef struct packed {
		word_t rdata;    // writeback value
		logic  misalign;
	} lsu_resp_t;

	// peer to memory request, addr is a word address
	typedef struct packed {
		addr_t addr;
		logic  we;
		strb_t strb;
		word_t wdata;
	} bus_req_t;

	typedef enum logic [1:0] {
		IDLE  = 2'b00,
		ISSUE = 2'b01,
		DATA  = 2'b11,
		HOLD  = 2'b10
	} lsu_state_e;

endpackage

`default_nettype wire

// ==== lsu_consts.svh ====
// widths, memory geometry and access size codes for the memory subsystem
// included by the package and by any module that needs a raw constant

`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

`define DATA_W     32          // data word width
`define ADDR_W     32          // byte address width
`define STRB_W     (`DATA_W/8) // one strobe bit per byte lane

// memory window seen by both fetch and load/store
`define MEM_WORDS  256         // 1 KB of words
`define MEM_AW     8           // word index bits, address wraps above this

// access size codes
`define SZ_B       2'b00
`define SZ_H       2'b01
`define SZ_W       2'b10

`endif
